//--- design/pf_pkg.sv
// Width constants, slice state enum and AR request structs of the prefetcher
`default_nettype none

package pf_pkg;

    localparam int ADDR_W = 32;   // AR address
    localparam int LEN_W  = 8;    // AXI4 burst length
    localparam int ID_W   = 4;
    localparam int WIN_W  = 4;    // Window size and credit count

    // Stride slice FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARM,
        ST_ACTIVE,
        ST_CLEANUP
    } pf_state_e;

    // One AR request on its way to the master port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   id;
    } pf_req_t;

    // An accepted slave request as the slices see it
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   id;
    } pf_obs_t;

endpackage

`default_nettype wire

//--- design/pf_req_router.sv
// Request router: slave AR acceptance, demand register and slice observation pulses
`default_nettype none

module pf_req_router #(
    parameter int NUM_SLICES = 4
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  s_ar_valid,
    output logic                  s_ar_ready,
    input  pf_pkg::pf_req_t       s_ar,
    output logic                  dem_valid,
    input  logic                  dem_ready,
    output pf_pkg::pf_req_t       dem,
    output pf_pkg::pf_obs_t       obs,
    output logic [NUM_SLICES-1:0] obs_valid
);

    logic                  accept;
    logic                  dem_valid_n;
    logic [NUM_SLICES-1:0] owner;       // One-hot slice that owns s_ar

    assign accept      = s_ar_valid && s_ar_ready;
    assign dem_valid_n = accept || (dem_valid && !dem_ready);

    // Owning slice is id modulo NUM_SLICES
    always_comb begin
        for (int i = 0; i < NUM_SLICES; i++) begin
            owner[i] = ((int'(s_ar.id) % NUM_SLICES) == i);
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            dem_valid  <= 1'b0;
            s_ar_ready <= 1'b0;
            obs_valid  <= '0;
        end else begin
            dem_valid  <= dem_valid_n;
            s_ar_ready <= !dem_valid_n;            // Reopens on the draining edge
            obs_valid  <= accept ? owner : '0;     // Single pulse per accepted request
        end
    end

    // Demand and observation carry the same request
    always_ff @(posedge clk) begin
        if (accept) begin
            dem      <= s_ar;
            obs.addr <= s_ar.addr;
            obs.len  <= s_ar.len;
            obs.id   <= s_ar.id;
        end
    end

    // Exactly one slice hears about each accepted request on the next cycle
    a_obs_onehot: assert property (@(posedge clk) disable iff (!resetN)
        |obs_valid |-> $onehot(obs_valid) && $past(s_ar_valid && s_ar_ready));

endmodule

`default_nettype wire

//--- design/pf_stride_slice.sv
// Stride slice: learning FSM, prefetch address generation, window credit and watchdog
`default_nettype none

module pf_stride_slice #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                      clk,
    input  logic                      resetN,
    input  logic                      ctrl_flush,
    input  logic                      obs_valid,
    input  pf_pkg::pf_obs_t           obs,
    input  logic [pf_pkg::ADDR_W-1:0] bar,
    input  logic [pf_pkg::ADDR_W-1:0] limit,
    input  logic [pf_pkg::WIN_W-1:0]  window_size,
    output logic                      pf_valid,
    input  logic                      pf_grant,
    output pf_pkg::pf_req_t           pf_req
);

    import pf_pkg::*;

    localparam int WD_W = $clog2(TIMEOUT_CYCLES + 1);

    pf_state_e         state;
    pf_state_e         state_n;
    logic [ID_W-1:0]   ctx_id;
    logic [LEN_W-1:0]  ctx_len;
    logic [ADDR_W-1:0] prev_addr;          // Last observed address
    logic [ADDR_W-1:0] stride;
    logic [ADDR_W-1:0] stride_n;
    logic [ADDR_W-1:0] pf_addr;            // Next address to prefetch
    logic [ADDR_W-1:0] pf_addr_n;
    logic [WIN_W-1:0]  credit;             // Prefetches ahead of demand
    logic [WIN_W-1:0]  credit_n;
    logic [WD_W-1:0]   wd_cnt;
    logic              flush_d;
    logic              pf_valid_n;

    logic [ADDR_W-1:0] obs_stride;
    logic              ctx_match;
    logic              same_stride;
    logic              new_stride;
    logic              flush_rise;
    logic              activity;
    logic              wd_expired;
    logic              pending;

    assign obs_stride  = obs.addr - prev_addr;    // Two's complement, negative strides wrap
    assign ctx_match   = (obs.id == ctx_id) && (obs.len == ctx_len);
    assign same_stride = (obs_stride == stride);
    assign new_stride  = (obs_stride != '0) && !same_stride;
    assign flush_rise  = ctrl_flush && !flush_d;
    assign activity    = obs_valid || pf_grant;
    assign wd_expired  = (wd_cnt == WD_W'(TIMEOUT_CYCLES));
    assign pending     = pf_valid && !pf_grant;

    always_comb begin
        state_n   = state;
        stride_n  = stride;
        pf_addr_n = pf_addr;
        credit_n  = credit;
        case (state)
            ST_IDLE: begin
                if (obs_valid) begin
                    state_n = ST_ARM;
                end
            end
            ST_ARM: begin
                if (flush_rise || (obs_valid && !ctx_match)) begin
                    state_n = ST_CLEANUP;
                end else if (obs_valid && obs_stride != '0) begin
                    state_n   = ST_ACTIVE;
                    stride_n  = obs_stride;
                    pf_addr_n = obs.addr + obs_stride;
                    credit_n  = '0;
                end
            end
            ST_ACTIVE: begin
                if (pf_grant) begin
                    pf_addr_n = pf_addr + stride;
                end
                if (flush_rise || (wd_expired && !activity) ||
                    (obs_valid && (!ctx_match || new_stride))) begin
                    state_n = ST_CLEANUP;
                end else if (obs_valid && same_stride) begin
                    // Demand moved one step closer, a grant in the same cycle cancels it
                    if (!pf_grant && credit != '0) begin
                        credit_n = credit - 1'b1;
                    end
                end else if (pf_grant) begin
                    credit_n = credit + 1'b1;
                end
            end
            ST_CLEANUP: begin
                if (!pending) begin             // Let the issued request drain first
                    state_n  = ST_IDLE;
                    credit_n = '0;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    // A raised request holds until granted, a new one needs room and range
    always_comb begin
        if (pending) begin
            pf_valid_n = 1'b1;
        end else begin
            pf_valid_n = (state_n == ST_ACTIVE) && (credit_n < window_size) &&
                         (pf_addr_n >= bar) && (pf_addr_n <= limit);
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state    <= ST_IDLE;
            credit   <= '0;
            wd_cnt   <= '0;
            flush_d  <= 1'b0;
            pf_valid <= 1'b0;
        end else begin
            state    <= state_n;
            credit   <= credit_n;
            flush_d  <= ctrl_flush;
            pf_valid <= pf_valid_n;
            if (state != ST_ACTIVE || activity) begin
                wd_cnt <= '0;
            end else if (!wd_expired) begin
                wd_cnt <= wd_cnt + 1'b1;
            end
        end
    end

    // Learned context
    always_ff @(posedge clk) begin
        if (obs_valid) begin
            prev_addr <= obs.addr;
        end
        if (state == ST_IDLE && obs_valid) begin
            ctx_id  <= obs.id;
            ctx_len <= obs.len;
        end
        stride  <= stride_n;
        pf_addr <= pf_addr_n;
    end

    assign pf_req = '{addr: pf_addr, len: ctx_len, id: ctx_id};

    // AXI stability toward the arbiter
    a_req_stable: assert property (@(posedge clk) disable iff (!resetN)
        pf_valid && !pf_grant |=> pf_valid && $stable(pf_req));

    // Cleanup must not return to idle with a request still out
    a_idle_quiet: assert property (@(posedge clk) disable iff (!resetN)
        state == ST_IDLE |-> !pf_valid);

endmodule

`default_nettype wire

//--- design/pf_ar_arbiter.sv
// AR arbiter: demand-first, round-robin prefetch drain into the master AR register
`default_nettype none

module pf_ar_arbiter #(
    parameter int NUM_SLICES = 4
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  dem_valid,
    output logic                  dem_ready,
    input  pf_pkg::pf_req_t       dem,
    input  logic [NUM_SLICES-1:0] pf_valid,
    output logic [NUM_SLICES-1:0] pf_grant,
    input  pf_pkg::pf_req_t       pf_req [NUM_SLICES],
    output logic                  m_ar_valid,
    input  logic                  m_ar_ready,
    output pf_pkg::pf_req_t       m_ar
);

    localparam int SEL_W = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic             load_ok;     // Output register free on this edge
    logic             pf_any;
    logic [SEL_W-1:0] rr_ptr;      // First slice to look at
    logic [SEL_W-1:0] pick;

    assign load_ok   = !m_ar_valid || m_ar_ready;
    assign dem_ready = load_ok;     // Demand always wins

    always_comb begin
        int cand;
        pf_any = 1'b0;
        pick   = rr_ptr;
        cand   = 0;
        for (int k = 0; k < NUM_SLICES; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_SLICES;
            if (!pf_any && pf_valid[cand]) begin
                pf_any = 1'b1;
                pick   = SEL_W'(cand);
            end
        end
    end

    always_comb begin
        pf_grant = '0;
        if (load_ok && !dem_valid && pf_any) begin
            pf_grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            m_ar_valid <= 1'b0;
            rr_ptr     <= '0;
        end else begin
            if (dem_valid && dem_ready) begin
                m_ar_valid <= 1'b1;
            end else if (|pf_grant) begin
                m_ar_valid <= 1'b1;
                rr_ptr     <= SEL_W'((int'(pick) + 1) % NUM_SLICES);  // Winner goes last
            end else if (m_ar_ready) begin
                m_ar_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dem_valid && dem_ready) begin
            m_ar <= dem;
        end else if (|pf_grant) begin
            m_ar <= pf_req[pick];
        end
    end

    // One grant at most, and only to a slice that asks
    a_grant_onehot: assert property (@(posedge clk) disable iff (!resetN)
        $onehot0(pf_grant) && ((pf_grant & ~pf_valid) == '0));

    a_m_ar_hold: assert property (@(posedge clk) disable iff (!resetN)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar));

endmodule

`default_nettype wire

//--- design/pf_top.sv
// Prefetcher top: request router, generate loop of stride slices and AR arbiter
`default_nettype none

module pf_top #(
    parameter int NUM_SLICES     = 4,
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                      clk,
    input  logic                      resetN,
    input  logic                      ctrl_flush,
    input  logic                      s_ar_valid,
    output logic                      s_ar_ready,
    input  pf_pkg::pf_req_t           s_ar,
    output logic                      m_ar_valid,
    input  logic                      m_ar_ready,
    output pf_pkg::pf_req_t           m_ar,
    input  logic [pf_pkg::ADDR_W-1:0] bar,
    input  logic [pf_pkg::ADDR_W-1:0] limit,
    input  logic [pf_pkg::WIN_W-1:0]  window_size
);

    import pf_pkg::*;

    logic                  dem_valid;
    logic                  dem_ready;
    pf_req_t               dem;
    pf_obs_t               obs;        // Shared by all slices
    logic [NUM_SLICES-1:0] obs_valid;
    logic [NUM_SLICES-1:0] pf_valid;
    logic [NUM_SLICES-1:0] pf_grant;
    pf_req_t               pf_req [NUM_SLICES];

    pf_req_router #(.NUM_SLICES(NUM_SLICES)) router_i (
        .clk        (clk),
        .resetN     (resetN),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_ar       (s_ar),
        .dem_valid  (dem_valid),
        .dem_ready  (dem_ready),
        .dem        (dem),
        .obs        (obs),
        .obs_valid  (obs_valid)
    );

    // One slice per ID group
    for (genvar g = 0; g < NUM_SLICES; g++) begin : g_slice
        pf_stride_slice #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) slice_i (
            .clk         (clk),
            .resetN      (resetN),
            .ctrl_flush  (ctrl_flush),
            .obs_valid   (obs_valid[g]),
            .obs         (obs),
            .bar         (bar),
            .limit       (limit),
            .window_size (window_size),
            .pf_valid    (pf_valid[g]),
            .pf_grant    (pf_grant[g]),
            .pf_req      (pf_req[g])
        );
    end

    pf_ar_arbiter #(.NUM_SLICES(NUM_SLICES)) arbiter_i (
        .clk        (clk),
        .resetN     (resetN),
        .dem_valid  (dem_valid),
        .dem_ready  (dem_ready),
        .dem        (dem),
        .pf_valid   (pf_valid),
        .pf_grant   (pf_grant),
        .pf_req     (pf_req),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_ar       (m_ar)
    );

endmodule

`default_nettype wire

//--- verif/pf_tb.sv
// Prefetcher testbench: stimulus table, LFSR stalls, compare task, reference model and watchdog
`default_nettype none

module pf_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pf_pkg::*;

    localparam int STEP_CYCLES = 40;           // Time budget per table request
    localparam logic [LEN_W-1:0] REQ_LEN = 8'h03;

    typedef struct {
        string       name;
        logic [3:0]  id;
        logic [31:0] start;
        logic [31:0] stride;
        int          count;
        logic [31:0] bar;
        logic [31:0] limit;
        logic [3:0]  win;
        int          brk_at;
        int          brk_kind;                 // 1 flush, 2 idle gap, 3 stride change
        int          stall;                    // m_ar_ready low when 2 LFSR bits < stall
        bit          dual;                     // Also drive id+1 on the next slice
        int          min_pf;                   // Prefetches needed since the last training
    } row_t;

    logic clk;
    logic resetN;
    logic ctrl_flush;
    logic s_ar_valid;
    logic s_ar_ready;
    logic m_ar_valid;
    logic m_ar_ready;
    pf_req_t s_ar;
    pf_req_t m_ar;
    logic [ADDR_W-1:0] bar;
    logic [ADDR_W-1:0] limit;
    logic [WIN_W-1:0]  window_size;

    row_t        rows[$];
    pf_req_t     dem_q[$];                     // Accepted slave requests not yet on m_ar
    int          phase[16];                    // 0 idle, 1 armed, 2 active
    logic [31:0] prev_a[16];
    logic [31:0] stride_a[16];
    logic [31:0] exp_a[16];
    bit          exp_ok[16];
    int          pf_cnt[16];
    int          budget[16];
    int          errors;
    int          stall_lvl;
    logic [31:0] lfsr;
    bit          held_v;
    pf_req_t     held;

    pf_top #(.NUM_SLICES(4), .TIMEOUT_CYCLES(64)) dut_i (
        .clk(clk), .resetN(resetN), .ctrl_flush(ctrl_flush),
        .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready), .s_ar(s_ar),
        .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready), .m_ar(m_ar),
        .bar(bar), .limit(limit), .window_size(window_size)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic void add_row(input string name, input logic [3:0] id,
            input logic [31:0] start, input logic [31:0] stride, input int count,
            input logic [31:0] b, input logic [31:0] l, input logic [3:0] win,
            input int brk_at, input int brk_kind, input int stall, input bit dual,
            input int min_pf);
        rows.push_back('{name, id, start, stride, count, b, l, win, brk_at, brk_kind,
                         stall, dual, min_pf});
    endfunction

    // Slice learning rules applied to one accepted request
    function automatic void note_request(input logic [3:0] id, input logic [31:0] addr);
        logic [31:0] s;
        s = addr - prev_a[id];
        if (phase[id] == 0) begin
            phase[id] = 1;
        end else if (phase[id] == 1 && s != 0) begin
            phase[id]    = 2;
            stride_a[id] = s;
            exp_a[id]    = addr + s;
            exp_ok[id]   = 1;
            pf_cnt[id]   = 0;
            budget[id]   = window_size;
        end else if (phase[id] == 2 && s == stride_a[id]) begin
            budget[id]++;                      // Demand caught up one step
        end else if (phase[id] == 2 && s != 0) begin
            phase[id] = 0;
        end
        prev_a[id] = addr;
    endfunction

    function automatic void forget_id(input logic [3:0] id);
        phase[id]  = 0;
        exp_ok[id] = 0;
    endfunction

    task automatic check_prefetch(input pf_req_t r);
        if (!exp_ok[r.id]) begin
            $display("Unexpected prefetch for id %0d at address %h", r.id, r.addr);
            errors++;
        end else begin
            check("m_ar.addr", r.addr, exp_a[r.id]);
            check("m_ar.len", r.len, REQ_LEN);
            pf_cnt[r.id]++;
            if (pf_cnt[r.id] > budget[r.id]) begin
                $display("Prefetch for id %0d runs beyond its window", r.id);
                errors++;
            end
            if (r.addr < bar || r.addr > limit) begin
                $display("Prefetch address %h lies outside bar and limit", r.addr);
                errors++;
            end
            exp_a[r.id] = exp_a[r.id] + stride_a[r.id];
        end
    endtask

    // m_ar_ready stalls driven after the edge
    always @(posedge clk) begin : stall_gen
        int lvl;
        lvl = stall_lvl;
        #2;
        lfsr = lfsr_step(lfsr);
        lfsr = lfsr_step(lfsr);
        m_ar_ready = (int'(lfsr[1:0]) >= lvl);
    end

    always @(posedge clk) begin : monitor
        int found;
        if (!resetN) begin
            held_v = 0;
        end else begin
            if (held_v) begin
                check("m_ar_valid", m_ar_valid, 1);
                check("m_ar", m_ar, held);
            end
            if (m_ar_valid && m_ar_ready) begin
                found = -1;
                for (int k = 0; k < dem_q.size(); k++) begin
                    if (found < 0 && dem_q[k].id == m_ar.id) found = k;
                end
                if (found >= 0 && dem_q[found].addr == m_ar.addr) begin
                    check("m_ar.len", m_ar.len, dem_q[found].len);
                    dem_q.delete(found);
                end else begin
                    check_prefetch(m_ar);
                end
            end
            held_v = m_ar_valid && !m_ar_ready;
            held   = m_ar;
        end
    end

    task automatic send_req(input logic [3:0] id, input logic [31:0] addr);
        s_ar_valid = 1;
        s_ar       = '{addr: addr, len: REQ_LEN, id: id};
        @(posedge clk);
        while (!s_ar_ready) @(posedge clk);   // Ready seen at the edge means accepted
        #2;
        dem_q.push_back(s_ar);
        note_request(id, addr);
        s_ar_valid = 0;
        repeat (4) @(posedge clk);
        #2;
    endtask

    // Flush or idle gap with stalls off so a pending prefetch drains
    task automatic pause_ids(input int kind, input logic [3:0] id, input bit dual);
        stall_lvl = 0;
        if (kind == 1) ctrl_flush = 1;
        repeat (kind == 2 ? 150 : 6) @(posedge clk);
        #2 ctrl_flush = 0;
        forget_id(id);
        if (dual) forget_id(4'(id + 1));
    endtask

    task automatic run_row(input row_t r, inout int failed);
        int err0;
        logic [31:0] a;
        err0 = errors;
        bar = r.bar;
        limit = r.limit;
        window_size = r.win;
        stall_lvl = r.stall;
        a = r.start;
        for (int i = 0; i < r.count; i++) begin
            if (i > 0) a += (r.brk_kind == 3 && i >= r.brk_at) ? 3 * r.stride : r.stride;
            if (i == r.brk_at && (r.brk_kind == 1 || r.brk_kind == 2)) begin
                pause_ids(r.brk_kind, r.id, r.dual);
                stall_lvl = r.stall;
            end
            send_req(r.id, a);
            if (r.dual) send_req(4'(r.id + 1), a + 32'h1_0000);
        end
        while (dem_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        #2;
        if (pf_cnt[r.id] < r.min_pf || (r.dual && pf_cnt[r.id + 1] < r.min_pf)) begin
            $display("Too few prefetches in test %s", r.name);
            errors++;
        end
        pause_ids(1, r.id, r.dual);           // Leave all slices idle for the next row
        if (errors != err0) failed++;
        $display("%-14s %s", r.name, (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin : watchdog
        int total;
        total = 0;
        #1;
        foreach (rows[i]) total += rows[i].count;
        #(total * STEP_CYCLES * 20);
        $display("Run stopped after exceeding its time limit");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int failed;
        clk = 0;
        resetN = 0;
        ctrl_flush = 0;
        s_ar_valid = 0;
        s_ar = '0;
        m_ar_ready = 1;
        bar = '0;
        limit = '1;
        window_size = '0;
        errors = 0;
        failed = 0;
        stall_lvl = 0;
        lfsr = 32'h355b_ff23;
        for (int i = 0; i < 16; i++) begin
            forget_id(i);
            pf_cnt[i] = 0;
        end
        add_row("basic_stride", 1, 32'h1000, 32'h40, 6, 0, '1, 4, 99, 0, 0, 0, 4);
        add_row("zero_stride", 2, 32'h2000, 32'h0, 5, 0, '1, 4, 99, 0, 0, 0, 0);
        add_row("bar_limit", 3, 32'h3000, 32'h100, 5, 32'h3000, 32'h3600, 8, 99, 0, 0, 0, 1);
        add_row("stride_change", 5, 32'h5000, 32'h80, 8, 0, '1, 4, 4, 3, 0, 0, 2);
        add_row("flush", 6, 32'h6000, 32'h20, 8, 0, '1, 3, 4, 1, 0, 0, 2);
        add_row("stall_dual", 8, 32'h8000, 32'h40, 10, 0, '1, 4, 99, 0, 2, 1, 1);
        add_row("timeout", 10, 32'ha000, 32'h10, 4, 0, '1, 2, 3, 2, 0, 0, 2);
        repeat (3) @(posedge clk);
        #2 resetN = 1;
        foreach (rows[i]) run_row(rows[i], failed);
        $display("Tests run %0d, failed %0d, errors %0d", rows.size(), failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/pf_pkg.sv
design/pf_req_router.sv
design/pf_stride_slice.sv
design/pf_ar_arbiter.sv
design/pf_top.sv
verif/pf_tb.sv
